// File: Makefile
TOP = muldiv_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: logic/div_iter.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module div_iter (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       start_i,
  input  muldiv_pkg::muldiv_op_e     op_i,
  input  logic [`MULDIV_XLEN-1:0]    rs1_i,
  input  logic [`MULDIV_XLEN-1:0]    rs2_i,
  input  logic [`MULDIV_TAG_W-1:0]   tag_i,
  output logic                       idle_o,
  wb_if.unit                         wb
);

  localparam int XLEN  = `MULDIV_XLEN;
  localparam int HALF  = `MULDIV_XLEN / 2;
  localparam int CNT_W = $clog2(`MULDIV_XLEN);

  muldiv_pkg::div_state_e state;

  // decode of the op arriving with start
  logic            op_w;
  logic            op_signed;
  logic            op_rem;
  logic [XLEN-1:0] a_val;
  logic [XLEN-1:0] b_val;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;
  logic            div_zero;
  logic            overflow;

  // shift subtract datapath
  logic [XLEN-1:0]          quo_q;
  logic [XLEN-1:0]          rem_q;
  logic [XLEN-1:0]          dvs_q;
  logic [CNT_W-1:0]         cnt_q;
  logic                     quo_neg_q;
  logic                     rem_neg_q;
  logic                     sel_rem_q;
  logic                     w_q;
  logic [`MULDIV_TAG_W-1:0] tag_q;
  logic [XLEN:0]            rem_shift;
  logic [XLEN:0]            rem_diff;

  // fix stage
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;
  logic [XLEN-1:0] res_raw;
  logic [XLEN-1:0] res_q;

  assign op_w      = muldiv_pkg::is_word_op(op_i);
  assign op_signed = (op_i == muldiv_pkg::DIV) || (op_i == muldiv_pkg::REM) ||
                     (op_i == muldiv_pkg::DIVW) || (op_i == muldiv_pkg::REMW);
  assign op_rem    = (op_i == muldiv_pkg::REM) || (op_i == muldiv_pkg::REMU) ||
                     (op_i == muldiv_pkg::REMW) || (op_i == muldiv_pkg::REMUW);

  // word ops see the low half widened by signedness
  assign a_val = op_w ? {{HALF{op_signed & rs1_i[HALF-1]}}, rs1_i[HALF-1:0]} : rs1_i;
  assign b_val = op_w ? {{HALF{op_signed & rs2_i[HALF-1]}}, rs2_i[HALF-1:0]} : rs2_i;

  // sign and magnitude can't share one loop so signs are handled apart
  assign a_neg = op_signed & a_val[XLEN-1];
  assign b_neg = op_signed & b_val[XLEN-1];
  assign a_abs = a_neg ? -a_val : a_val;
  assign b_abs = b_neg ? -b_val : b_val;

  // rv special cases
  assign div_zero = (b_val == '0);
  assign overflow = op_signed & (&b_val) &
                    (op_w ? (rs1_i[HALF-1:0] == {1'b1, {(HALF-1){1'b0}}})
                          : (rs1_i == {1'b1, {(XLEN-1){1'b0}}}));

  // one restoring step
  // a clear top bit of the difference means the divisor fits
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_q};

  assign quo_fix = quo_neg_q ? -quo_q : quo_q;
  assign rem_fix = rem_neg_q ? -rem_q : rem_q;
  assign res_raw = sel_rem_q ? rem_fix : quo_fix;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= muldiv_pkg::IDLE;
    end else begin
      case (state)
        muldiv_pkg::IDLE: if (start_i) begin
          state <= (div_zero || overflow) ? muldiv_pkg::FIX : muldiv_pkg::CALC;
        end
        muldiv_pkg::CALC: if (cnt_q == '0) state <= muldiv_pkg::FIX;
        muldiv_pkg::FIX:  state <= muldiv_pkg::DONE;
        muldiv_pkg::DONE: if (wb.grant) state <= muldiv_pkg::IDLE;
        default:          state <= muldiv_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      muldiv_pkg::IDLE: if (start_i) begin
        tag_q     <= tag_i;
        sel_rem_q <= op_rem;
        w_q       <= op_w;
        dvs_q     <= b_abs;
        cnt_q     <= op_w ? CNT_W'(HALF - 1) : CNT_W'(XLEN - 1);
        if (div_zero) begin
          // all ones quotient and the dividend as remainder
          quo_q     <= '1;
          rem_q     <= a_val;
          quo_neg_q <= 1'b0;
          rem_neg_q <= 1'b0;
        end else if (overflow) begin
          quo_q     <= a_val;
          rem_q     <= '0;
          quo_neg_q <= 1'b0;
          rem_neg_q <= 1'b0;
        end else begin
          // word dividend sits in the top half so 32 steps consume it
          quo_q     <= op_w ? {a_abs[HALF-1:0], {HALF{1'b0}}} : a_abs;
          rem_q     <= '0;
          quo_neg_q <= a_neg ^ b_neg;
          // remainder takes the dividend's sign
          rem_neg_q <= a_neg;
        end
      end
      muldiv_pkg::CALC: begin
        cnt_q <= cnt_q - 1'b1;
        if (!rem_diff[XLEN]) begin
          rem_q <= rem_diff[XLEN-1:0];
          quo_q <= {quo_q[XLEN-2:0], 1'b1};
        end else begin
          rem_q <= rem_shift[XLEN-1:0];
          quo_q <= {quo_q[XLEN-2:0], 1'b0};
        end
      end
      // word results are sign extended per rv64
      muldiv_pkg::FIX: res_q <= w_q ? {{HALF{res_raw[HALF-1]}}, res_raw[HALF-1:0]} : res_raw;
      default: ;
    endcase
  end

  // a pending start already counts as busy
  assign idle_o   = (state == muldiv_pkg::IDLE) && !start_i;
  assign wb.valid = (state == muldiv_pkg::DONE);
  assign wb.data  = res_q;
  assign wb.tag   = tag_q;

endmodule

// File: logic/mul_pipe.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module mul_pipe (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       start_i,
  input  muldiv_pkg::muldiv_op_e     op_i,
  input  logic [`MULDIV_XLEN-1:0]    rs1_i,
  input  logic [`MULDIV_XLEN-1:0]    rs2_i,
  input  logic [`MULDIV_TAG_W-1:0]   tag_i,
  output logic                       ready_o,
  wb_if.unit                         wb
);

  localparam int XLEN = `MULDIV_XLEN;
  localparam int HALF = `MULDIV_XLEN / 2;
  localparam int NS   = `MULDIV_MUL_STAGES;

  // one valid bit per stage
  // bit 0 is stage 1 and the top bit is the offered result
  logic [NS-1:0] vld_q;
  logic          stall;

  // stage 1 inputs
  logic                 op_w;
  logic                 a_sgn;
  logic                 b_sgn;
  logic signed [XLEN:0] a_ext;
  logic signed [XLEN:0] b_ext;

  // stage 1 regs
  logic signed [XLEN:0]       a1_q;
  logic signed [XLEN:0]       b1_q;
  muldiv_pkg::muldiv_op_e     op1_q;
  logic [`MULDIV_TAG_W-1:0]   tag1_q;

  // stage 2 regs
  logic signed [2*XLEN+1:0]   prod_full;
  logic [2*XLEN-1:0]          prod2_q;
  muldiv_pkg::muldiv_op_e     op2_q;
  logic [`MULDIV_TAG_W-1:0]   tag2_q;

  // stage 3 regs
  logic [XLEN-1:0]            res_sel;
  logic [XLEN-1:0]            res3_q;
  logic [`MULDIV_TAG_W-1:0]   tag3_q;

  // the whole pipe freezes while the last stage waits for grant
  assign stall   = vld_q[NS-1] & ~wb.grant;
  assign ready_o = ~stall;

  // operand signedness per op
  // MUL and MULW only keep the low half so the extension is irrelevant there
  assign op_w  = muldiv_pkg::is_word_op(op_i);
  assign a_sgn = (op_i == muldiv_pkg::MULH) || (op_i == muldiv_pkg::MULHSU);
  assign b_sgn = (op_i == muldiv_pkg::MULH);

  // 65 bit operands so one signed multiplier covers all variants
  assign a_ext = op_w ? {{(XLEN - HALF + 1){rs1_i[HALF-1]}}, rs1_i[HALF-1:0]}
                      : {a_sgn & rs1_i[XLEN-1], rs1_i};
  assign b_ext = op_w ? {{(XLEN - HALF + 1){rs2_i[HALF-1]}}, rs2_i[HALF-1:0]}
                      : {b_sgn & rs2_i[XLEN-1], rs2_i};

  // full signed product
  // the low 128 bits are exact for every sign mix
  assign prod_full = a1_q * b1_q;

  // result half select
  always_comb begin
    case (op2_q)
      muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU:
        res_sel = prod2_q[2*XLEN-1:XLEN];
      muldiv_pkg::MULW:
        res_sel = {{HALF{prod2_q[HALF-1]}}, prod2_q[HALF-1:0]};
      default:
        res_sel = prod2_q[XLEN-1:0];
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else if (!stall) begin
      vld_q <= {vld_q[NS-2:0], start_i};
    end
  end

  // payload advances with the valids and has no reset
  always_ff @(posedge clk) begin
    if (!stall) begin
      a1_q    <= a_ext;
      b1_q    <= b_ext;
      op1_q   <= op_i;
      tag1_q  <= tag_i;
      prod2_q <= prod_full[2*XLEN-1:0];
      op2_q   <= op1_q;
      tag2_q  <= tag1_q;
      res3_q  <= res_sel;
      tag3_q  <= tag2_q;
    end
  end

  // offer towards the arbiter
  assign wb.valid = vld_q[NS-1];
  assign wb.data  = res3_q;
  assign wb.tag   = tag3_q;

endmodule

// File: logic/muldiv_config.svh
`ifndef MULDIV_CONFIG_SVH
`define MULDIV_CONFIG_SVH

// datapath width of the core
// word ops use the low half of this
`define MULDIV_XLEN 64

// destination tag carried with every op
// 5 bits covers one tag per architectural register
`define MULDIV_TAG_W 5

// multiplier depth counted from the dispatch register
// stage 1 extends the operands
// stage 2 forms the full product
// stage 3 picks the result half
`define MULDIV_MUL_STAGES 3

`endif

// File: logic/muldiv_dispatch.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module muldiv_dispatch (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       op_valid_i,
  input  muldiv_pkg::muldiv_op_e     op_i,
  input  logic [`MULDIV_XLEN-1:0]    rs1_i,
  input  logic [`MULDIV_XLEN-1:0]    rs2_i,
  input  logic [`MULDIV_TAG_W-1:0]   tag_i,
  input  logic                       mul_ready_i,
  input  logic                       div_idle_i,
  output logic                       accept_o,
  output logic                       mul_start_o,
  output logic                       div_start_o,
  output muldiv_pkg::muldiv_op_e     op_o,
  output logic [`MULDIV_XLEN-1:0]    rs1_o,
  output logic [`MULDIV_XLEN-1:0]    rs2_o,
  output logic [`MULDIV_TAG_W-1:0]   tag_o
);

  logic to_div;
  logic hold;
  logic take;

  // steer by op class
  assign to_div = muldiv_pkg::is_div_op(op_i);

  // a registered multiply start that meets a stalled pipe must wait here
  // this register then acts as stage 0 of the multiplier
  assign hold = mul_start_o & ~mul_ready_i;

  // accept follows the readiness of the unit the op goes to
  // a held multiply also blocks divides since the payload regs are shared
  assign accept_o = ~hold & (to_div ? div_idle_i : mul_ready_i);

  assign take = op_valid_i & accept_o;

  // start strobes
  // one cycle for the divider
  // the multiply strobe stretches only while held
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mul_start_o <= 1'b0;
      div_start_o <= 1'b0;
    end else if (!hold) begin
      mul_start_o <= take & ~to_div;
      div_start_o <= take & to_div;
    end
  end

  // payload only moves on an accepted op
  // while held take is low so the stalled multiply keeps its operands
  always_ff @(posedge clk) begin
    if (take) begin
      op_o  <= op_i;
      rs1_o <= rs1_i;
      rs2_o <= rs2_i;
      tag_o <= tag_i;
    end
  end

endmodule

// File: logic/muldiv_pkg.sv
package muldiv_pkg;

  // rv64m operation codes as seen by the execution block
  // plain ops first, word ops grouped at the end
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHSU = 4'd2,
    MULHU  = 4'd3,
    DIV    = 4'd4,
    DIVU   = 4'd5,
    REM    = 4'd6,
    REMU   = 4'd7,
    MULW   = 4'd8,
    DIVW   = 4'd9,
    DIVUW  = 4'd10,
    REMW   = 4'd11,
    REMUW  = 4'd12
  } muldiv_op_e;

  // divider FSM
  // CALC runs one quotient bit per cycle
  // FIX applies signs and picks quotient or remainder
  // DONE holds the result until the arbiter grants it
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    FIX  = 2'd2,
    DONE = 2'd3
  } div_state_e;

  // true for every op handled by the divider
  function automatic logic is_div_op(muldiv_op_e op);
    case (op)
      DIV, DIVU, REM, REMU, DIVW, DIVUW, REMW, REMUW: is_div_op = 1'b1;
      default: is_div_op = 1'b0;
    endcase
  endfunction

  // true for the 32 bit word ops
  // their result is sign extended from bit 31
  function automatic logic is_word_op(muldiv_op_e op);
    case (op)
      MULW, DIVW, DIVUW, REMW, REMUW: is_word_op = 1'b1;
      default: is_word_op = 1'b0;
    endcase
  endfunction

endpackage

// File: logic/muldiv_top.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module muldiv_top (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       op_valid_i,
  input  muldiv_pkg::muldiv_op_e     op_i,
  input  logic [`MULDIV_XLEN-1:0]    rs1_i,
  input  logic [`MULDIV_XLEN-1:0]    rs2_i,
  input  logic [`MULDIV_TAG_W-1:0]   tag_i,
  output logic                       accept_o,
  output logic                       wb_valid_o,
  output logic [`MULDIV_XLEN-1:0]    wb_data_o,
  output logic [`MULDIV_TAG_W-1:0]   wb_tag_o,
  output logic                       div_busy_o
);

  // dispatch register outputs shared by both units
  logic                     mul_start;
  logic                     div_start;
  muldiv_pkg::muldiv_op_e   disp_op;
  logic [`MULDIV_XLEN-1:0]  disp_rs1;
  logic [`MULDIV_XLEN-1:0]  disp_rs2;
  logic [`MULDIV_TAG_W-1:0] disp_tag;

  // unit status back to the dispatcher
  logic mul_ready;
  logic div_idle;

  wb_if mul_wb ();
  wb_if div_wb ();

  muldiv_dispatch u_dispatch (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .op_valid_i  (op_valid_i),
    .op_i        (op_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .tag_i       (tag_i),
    .mul_ready_i (mul_ready),
    .div_idle_i  (div_idle),
    .accept_o    (accept_o),
    .mul_start_o (mul_start),
    .div_start_o (div_start),
    .op_o        (disp_op),
    .rs1_o       (disp_rs1),
    .rs2_o       (disp_rs2),
    .tag_o       (disp_tag)
  );

  mul_pipe u_mul (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (mul_start),
    .op_i     (disp_op),
    .rs1_i    (disp_rs1),
    .rs2_i    (disp_rs2),
    .tag_i    (disp_tag),
    .ready_o  (mul_ready),
    .wb       (mul_wb)
  );

  div_iter u_div (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (div_start),
    .op_i     (disp_op),
    .rs1_i    (disp_rs1),
    .rs2_i    (disp_rs2),
    .tag_i    (disp_tag),
    .idle_o   (div_idle),
    .wb       (div_wb)
  );

  wb_arbiter u_arb (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .mul_wb     (mul_wb),
    .div_wb     (div_wb),
    .wb_valid_o (wb_valid_o),
    .wb_data_o  (wb_data_o),
    .wb_tag_o   (wb_tag_o)
  );

  // busy from the accept edge until the divider result is granted
  assign div_busy_o = ~div_idle;

endmodule

// File: logic/wb_arbiter.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module wb_arbiter (
  input  logic                       clk,
  input  logic                       arst_n_i,
  wb_if.arb                          mul_wb,
  wb_if.arb                          div_wb,
  output logic                       wb_valid_o,
  output logic [`MULDIV_XLEN-1:0]    wb_data_o,
  output logic [`MULDIV_TAG_W-1:0]   wb_tag_o
);

  logic any_valid;

  // fixed priority
  // divider wins since it blocks further divides until drained
  // the multiplier just stalls one cycle
  assign div_wb.grant = div_wb.valid;
  assign mul_wb.grant = mul_wb.valid & ~div_wb.valid;

  // the port is never back pressured so any offer gets a grant
  assign any_valid = div_wb.valid | mul_wb.valid;

  // output strobe
  // each grant consumes its offer so one result gives one pulse
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= any_valid;
    end
  end

  // winner's payload
  // held when idle
  always_ff @(posedge clk) begin
    if (div_wb.valid) begin
      wb_data_o <= div_wb.data;
      wb_tag_o  <= div_wb.tag;
    end else if (mul_wb.valid) begin
      wb_data_o <= mul_wb.data;
      wb_tag_o  <= mul_wb.tag;
    end
  end

endmodule

// File: logic/wb_if.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

// one execution unit's writeback offer towards the arbiter
// valid stays up until grant is seen in the same cycle
interface wb_if;

  logic                     valid;
  logic [`MULDIV_XLEN-1:0]  data;
  logic [`MULDIV_TAG_W-1:0] tag;
  // grant consumes the offer at the next edge
  logic                     grant;

  // unit drives the offer and watches grant
  modport unit (
    output valid, data, tag,
    input  grant
  );

  // arbiter sees the offer and answers with grant
  modport arb (
    input  valid, data, tag,
    output grant
  );

endinterface

// File: sim.f
+incdir+logic
logic/muldiv_pkg.sv
logic/wb_if.sv
logic/muldiv_dispatch.sv
logic/mul_pipe.sv
logic/div_iter.sv
logic/wb_arbiter.sv
logic/muldiv_top.sv
tb/muldiv_chk.sv
tb/muldiv_tb.sv

// File: tb/muldiv_chk.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module muldiv_chk (
  input logic                     clk,
  input logic                     arst_n_i,
  input logic                     mul_valid_i,
  input logic                     mul_grant_i,
  input logic                     div_valid_i,
  input logic                     div_start_i,
  input muldiv_pkg::div_state_e   div_state_i,
  input logic                     wb_valid_i,
  input logic [`MULDIV_TAG_W-1:0] wb_tag_i
);

  // count of failed assertions
  int fail_cnt = 0;

  // at most one winner per cycle
  // a shared cycle goes to the divider so the multiply offer is still there next cycle
  one_grant: assert property (@(posedge clk) disable iff (!arst_n_i)
    (mul_valid_i && div_valid_i) |=> (mul_valid_i && mul_grant_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("multiply offer not served right after a shared cycle");
    end

  // a start only reaches an idle divider
  start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    div_start_i |-> div_state_i == muldiv_pkg::IDLE)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("divider started outside IDLE");
    end

  // one pulse per result
  one_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    (wb_valid_i && $past(wb_valid_i)) |-> wb_tag_i != $past(wb_tag_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("writeback repeated tag %0d on back to back cycles", wb_tag_i);
    end

  // offers are held until granted
  mul_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (mul_valid_i && !mul_grant_i) |=> mul_valid_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("multiplier dropped an ungranted offer");
    end

endmodule

bind muldiv_top muldiv_chk u_chk (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .mul_valid_i (mul_wb.valid),
  .mul_grant_i (mul_wb.grant),
  .div_valid_i (div_wb.valid),
  .div_start_i (div_start),
  .div_state_i (u_div.state),
  .wb_valid_i  (wb_valid_o),
  .wb_tag_i    (wb_tag_o)
);

// File: tb/muldiv_tb.sv
`timescale 1ns/100ps
`include "muldiv_config.svh"

module muldiv_tb;

  localparam int NUM_RAND = 300;
  // directed ops stay below 60
  localparam int NUM_OPS = NUM_RAND + 60;
  localparam int CYCLE_LIMIT = NUM_OPS * 70 + 40 * `MULDIV_MUL_STAGES;
  localparam int NTAGS = 1 << `MULDIV_TAG_W;
  localparam logic [63:0] MIN64 = {1'b1, 63'd0};

  logic                     clk = 1'b0;
  logic                     arst_n_i;
  logic                     op_valid_i;
  muldiv_pkg::muldiv_op_e   op_i;
  logic [`MULDIV_XLEN-1:0]  rs1_i;
  logic [`MULDIV_XLEN-1:0]  rs2_i;
  logic [`MULDIV_TAG_W-1:0] tag_i;
  logic                     accept_o;
  logic                     wb_valid_o;
  logic [`MULDIV_XLEN-1:0]  wb_data_o;
  logic [`MULDIV_TAG_W-1:0] wb_tag_o;
  logic                     div_busy_o;

  integer seed;
  int issued;
  int returned;
  int data_err;
  int tag_err;
  int accept_err;
  int hang_err;
  int cycle_cnt;
  // per tag toggles
  // a tag is in flight while its two bits differ
  bit [NTAGS-1:0]           sent_tgl;
  bit [NTAGS-1:0]           back_tgl;
  logic [63:0]              exp_data [NTAGS];
  muldiv_pkg::muldiv_op_e   exp_op [NTAGS];
  logic [`MULDIV_TAG_W-1:0] next_tag;

  muldiv_top UUT (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .op_valid_i (op_valid_i),
    .op_i       (op_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .tag_i      (tag_i),
    .accept_o   (accept_o),
    .wb_valid_o (wb_valid_o),
    .wb_data_o  (wb_data_o),
    .wb_tag_o   (wb_tag_o),
    .div_busy_o (div_busy_o)
  );

  always #2 clk = ~clk;

  function automatic bit goes_to_divider(input muldiv_pkg::muldiv_op_e op);
    goes_to_divider = op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU, muldiv_pkg::REM,
                                 muldiv_pkg::REMU, muldiv_pkg::DIVW, muldiv_pkg::DIVUW,
                                 muldiv_pkg::REMW, muldiv_pkg::REMUW};
  endfunction

  function automatic logic [63:0] sext_word(input logic [31:0] v);
    sext_word = {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] mul_ref(input muldiv_pkg::muldiv_op_e op,
                                          input logic [63:0] a, input logic [63:0] b);
    logic [127:0] xa;
    logic [127:0] xb;
    logic [127:0] p;
    // widen each operand by its signedness
    // the low 128 product bits are then exact
    xa = {{64{(op == muldiv_pkg::MULH || op == muldiv_pkg::MULHSU) & a[63]}}, a};
    xb = {{64{(op == muldiv_pkg::MULH) & b[63]}}, b};
    p  = xa * xb;
    case (op)
      muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU: mul_ref = p[127:64];
      muldiv_pkg::MULW: mul_ref = sext_word(p[31:0]);
      default: mul_ref = p[63:0];
    endcase
  endfunction

  // 64 bit divide with the rv results for zero divisor and overflow
  function automatic logic [63:0] div_ref(input logic [63:0] a, input logic [63:0] b,
                                          input bit sgn, input bit want_rem);
    logic [63:0] q;
    logic [63:0] r;
    if (b == 64'd0) begin
      q = '1;
      r = a;
    end else if (sgn && a == MIN64 && b == '1) begin
      q = a;
      r = '0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    div_ref = want_rem ? r : q;
  endfunction

  function automatic logic [63:0] expected_result(input muldiv_pkg::muldiv_op_e op,
                                                  input logic [63:0] a, input logic [63:0] b);
    bit sgn;
    bit rem;
    bit word;
    logic [63:0] r;
    sgn  = op inside {muldiv_pkg::DIV, muldiv_pkg::REM, muldiv_pkg::DIVW, muldiv_pkg::REMW};
    rem  = op inside {muldiv_pkg::REM, muldiv_pkg::REMU, muldiv_pkg::REMW, muldiv_pkg::REMUW};
    word = op inside {muldiv_pkg::DIVW, muldiv_pkg::DIVUW, muldiv_pkg::REMW, muldiv_pkg::REMUW};
    if (!goes_to_divider(op)) return mul_ref(op, a, b);
    if (!word) return div_ref(a, b, sgn, rem);
    // word divide on the widened low halves
    // signed word overflow falls out of the 64 bit math
    r = div_ref(sgn ? sext_word(a[31:0]) : {32'd0, a[31:0]},
                sgn ? sext_word(b[31:0]) : {32'd0, b[31:0]}, sgn, rem);
    return sext_word(r[31:0]);
  endfunction

  // operands lean on zero, all ones, the minimum and small values
  function automatic logic [63:0] pick_operand();
    case ($unsigned($random(seed)) % 8)
      0: pick_operand = '0;
      1: pick_operand = '1;
      2: pick_operand = MIN64;
      3: pick_operand = {$random(seed), 32'h8000_0000};
      4: pick_operand = 64'($unsigned($random(seed)) % 16);
      5: pick_operand = -64'($unsigned($random(seed)) % 16);
      default: pick_operand = {$random(seed), $random(seed)};
    endcase
  endfunction

  function automatic muldiv_pkg::muldiv_op_e pick_op();
    pick_op = muldiv_pkg::muldiv_op_e'(4'($unsigned($random(seed)) % 13));
  endfunction

  task automatic check_idle_outputs();
    @(negedge clk);
    if (wb_valid_o || div_busy_o || !accept_o) begin
      $display("Fail %0t: idle outputs wb_valid %b div_busy %b accept %b", $time,
               wb_valid_o, div_busy_o, accept_o);
      accept_err++;
    end
  endtask

  // drive one op until taken and record its expected result by tag
  task automatic issue(input muldiv_pkg::muldiv_op_e op, input logic [63:0] a,
                       input logic [63:0] b);
    logic [`MULDIV_TAG_W-1:0] tag;
    bit taken;
    bit refused;
    taken   = 1'b0;
    refused = 1'b0;
    while (issued - returned >= NTAGS) begin
      @(posedge clk);
      #1;
    end
    tag = next_tag;
    while (sent_tgl[tag] != back_tgl[tag]) tag = tag + 5'd1;
    op_valid_i = 1'b1;
    op_i       = op;
    rs1_i      = a;
    rs2_i      = b;
    tag_i      = tag;
    while (!taken) begin
      @(negedge clk);
      // a multiply is only refused in the cycle the divider offers
      if (refused && div_busy_o) begin
        $display("Fail %0t: divider still busy a cycle after a multiply was refused", $time);
        accept_err++;
      end
      refused = 1'b0;
      if (!div_busy_o && !accept_o) begin
        $display("Fail %0t: %s refused with the divider idle", $time, op.name());
        accept_err++;
      end else if (div_busy_o && goes_to_divider(op) && accept_o) begin
        $display("Fail %0t: %s accepted while the divider is busy", $time, op.name());
        accept_err++;
      end else if (div_busy_o && !accept_o && !goes_to_divider(op)) begin
        refused = 1'b1;
      end
      taken = accept_o;
      @(posedge clk);
      #1;
    end
    exp_data[tag] = expected_result(op, a, b);
    exp_op[tag]   = op;
    sent_tgl[tag] = ~sent_tgl[tag];
    issued++;
    next_tag   = tag + 5'd1;
    op_valid_i = 1'b0;
  endtask

  task automatic finish_run();
    int total;
    total = data_err + tag_err + accept_err + hang_err + UUT.u_chk.fail_cnt;
    $display("errors: data %0d tag %0d accept %0d timeout %0d assert %0d (%0d results)",
             data_err, tag_err, accept_err, hang_err, UUT.u_chk.fail_cnt, returned);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // scoreboard by tag
  always @(negedge clk) begin
    if (arst_n_i && wb_valid_o) begin
      if (sent_tgl[wb_tag_o] == back_tgl[wb_tag_o]) begin
        $display("result returned on tag %0d which has no operation in flight (time %0t)",
                 wb_tag_o, $time);
        tag_err++;
      end else begin
        if (wb_data_o !== exp_data[wb_tag_o]) begin
          $display("Fail %0t: %s tag %0d returned %h expected %h", $time,
                   exp_op[wb_tag_o].name(), wb_tag_o, wb_data_o, exp_data[wb_tag_o]);
          data_err++;
        end
        back_tgl[wb_tag_o] = ~back_tgl[wb_tag_o];
        returned++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: run hung after %0d cycles with %0d results missing", cycle_cnt,
               issued - returned);
      hang_err = 1;
      finish_run();
    end
  end

  initial begin
    muldiv_pkg::muldiv_op_e op;
    seed       = 91912;
    arst_n_i   = 1'b0;
    op_valid_i = 1'b0;
    op_i       = muldiv_pkg::MUL;
    rs1_i      = '0;
    rs2_i      = '0;
    tag_i      = '0;
    next_tag   = '0;
    repeat (9) @(posedge clk);
    check_idle_outputs();
    @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    check_idle_outputs();
    @(posedge clk);
    #1;
    // every multiply variant back to back
    repeat (3) begin
      for (int k = 0; k < 13; k++) begin
        op = muldiv_pkg::muldiv_op_e'(4'(k));
        if (!goes_to_divider(op)) issue(op, pick_operand(), pick_operand());
      end
    end
    // zero divisor plus 64 bit and word overflow for every divide variant
    for (int k = 0; k < 13; k++) begin
      op = muldiv_pkg::muldiv_op_e'(4'(k));
      if (goes_to_divider(op)) begin
        issue(op, pick_operand(), '0);
        issue(op, MIN64, '1);
        issue(op, 64'h0000_0001_8000_0000, 64'h0000_0000_ffff_ffff);
      end
    end
    // a fast divide lands on the same cycle as a multiply
    repeat (4) begin
      issue(muldiv_pkg::MULHU, pick_operand(), pick_operand());
      issue(muldiv_pkg::REMUW, pick_operand(), '0);
      issue(muldiv_pkg::MUL, pick_operand(), pick_operand());
      issue(muldiv_pkg::MULW, pick_operand(), pick_operand());
    end
    // random mix with the odd idle cycle
    repeat (NUM_RAND) begin
      if (($random(seed) & 7) == 0) begin
        @(posedge clk);
        #1;
      end
      issue(pick_op(), pick_operand(), pick_operand());
    end
    while (returned != issued) @(posedge clk);
    repeat (8) @(posedge clk);
    finish_run();
  end

endmodule
